// ==== lock_settings.svh ====
`ifndef LOCK_SETTINGS_SVH
`define LOCK_SETTINGS_SVH

// Code geometry
`define CODE_DIGITS     20
`define NUM_USER_CODES  4

// All times in clock cycles, one cycle per millisecond
`define DEBOUNCE_MS     100    // Button hold time
`define RETRY_MS        1000   // Keypad lock after a wrong code
`define BLOCK_MS        30000  // Keypad lock once the attempts run out
`define MS_PER_SEC      1000   // Configured seconds to cycles

// Failures tolerated before the long lockout
`define MAX_ATTEMPTS    5

`endif

// ==== lock_pkg.sv ====
`include "lock_settings.svh"

package lock_pkg;

    typedef logic [3:0] digit_t;                // One keypad or display digit

    localparam digit_t DIGIT_BAR     = 4'hA;    // Lit bar on the display
    localparam digit_t DIGIT_BLANK   = 4'hB;    // Blank digit, "#" on the keypad
    localparam digit_t DIGIT_TIMEOUT = 4'hE;    // Keypad gave up waiting
    localparam digit_t DIGIT_EMPTY   = 4'hF;    // Nothing entered

    typedef digit_t [`CODE_DIGITS-1:0] code_t;  // Digit 0 is the last one typed

    // Keypad word, read whole or by its lowest digit
    typedef union packed {
        code_t code;
        struct packed {
            logic [(`CODE_DIGITS-1)*4-1:0] pad;
            digit_t                        cmd;
        } command;
    } key_entry_u;

    typedef struct packed {
        logic                             beep_en;       // Open-door beep allowed
        logic [7:0]                       beep_sec;      // Open time before beeping
        logic [7:0]                       autolock_sec;  // Ajar time before relocking
        code_t                            master;
        code_t [`NUM_USER_CODES-1:0]      user;
    } lock_cfg_t;

    typedef digit_t [5:0] bcd_t;                // Six display digits, digit 0 lowest

    typedef enum logic [4:0] {
        ST_INIT,
        ST_CLOSED,       // Latch engaged, keypad live
        ST_UNLOCK_DB,    // Inside button held to unlock
        ST_USER_CHK,     // Send entry to the matcher
        ST_USER_WAIT,
        ST_LOCKOUT,      // Keypad blocked after a wrong code
        ST_BEEP_TO,      // Single beep on keypad timeout
        ST_AJAR,         // Latch released, door still shut
        ST_RELOCK_DB,    // Inside button held to relock
        ST_OPEN,
        ST_BEEP_OPEN,    // Door left open too long
        ST_CFG_DB,       // Config button held
        ST_MASTER_IDLE,  // Waiting for the master code
        ST_MASTER_CHK,
        ST_MASTER_WAIT,
        ST_SETUP
    } door_state_t;

    typedef logic [3:0] attempt_t;              // Saturating failure count

endpackage

// ==== code_check_if.sv ====
`timescale 1ns/1ps

// One code check in flight at a time, done closes it
interface code_check_if import lock_pkg::*; ();

    logic  start;       // One-cycle request
    logic  master_sel;  // Compare against the master code only
    code_t entry;       // Held until done
    logic  done;        // One-cycle answer
    logic  match;       // Valid with done

    modport ctrl (
        output start, master_sel, entry,
        input  done, match
    );

    modport matcher (
        input  start, master_sel, entry,
        output done, match
    );

endinterface

// ==== code_match.sv ====
`timescale 1ns/1ps
`include "lock_settings.svh"

module code_match import lock_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  lock_cfg_t     cfg,
    code_check_if.matcher chk
);

    localparam int IDX_W = (`NUM_USER_CODES > 1) ? $clog2(`NUM_USER_CODES) : 1;

    logic             busy;       // Request accepted, answer pending
    logic             is_master;
    logic [IDX_W-1:0] idx;        // User slot under test
    code_t            ref_code;
    logic             hit;
    logic             last;       // No further slot to try

    // Stored word compared this cycle
    always_comb begin
        if (is_master)
            ref_code = cfg.master;
        else
            ref_code = cfg.user[idx];
    end

    assign hit  = (chk.entry == ref_code);
    assign last = is_master || (idx == IDX_W'(`NUM_USER_CODES - 1));

    // Answer as soon as a slot matches or the list is exhausted
    assign chk.done  = busy && (hit || last);
    assign chk.match = busy && hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            is_master <= 1'b0;
            idx       <= '0;
        end else begin
            if (chk.start) begin
                busy      <= 1'b1;
                is_master <= chk.master_sel;
                idx       <= '0;         // Always start from slot 0
            end else if (chk.done) begin
                busy <= 1'b0;
            end else if (busy) begin
                idx <= idx + 1'b1;       // Next user slot
            end
        end
    end

endmodule

// ==== lockout_ctrl.sv ====
`timescale 1ns/1ps
`include "lock_settings.svh"

module lockout_ctrl import lock_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic fail,            // Wrong user code, one cycle
    input  logic clear,           // Good user code, one cycle
    output logic keypad_release,  // Lockout over, one cycle
    output bcd_t bcd
);

    localparam int TMR_W = $clog2(`BLOCK_MS);

    attempt_t         attempts;
    attempt_t         attempts_inc;
    logic             blocking;   // Keypad held off
    logic             long_blk;   // Long lockout selected
    logic [TMR_W-1:0] tmr;
    logic [TMR_W-1:0] tmr_last;

    // Count saturates at all ones
    assign attempts_inc = (attempts == '1) ? attempts : attempts + 1'b1;

    assign tmr_last = long_blk ? TMR_W'(`BLOCK_MS - 1) : TMR_W'(`RETRY_MS - 1);

    assign keypad_release = blocking && (tmr == tmr_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            attempts <= '0;
            blocking <= 1'b0;
            long_blk <= 1'b0;
            tmr      <= '0;
        end else begin
            if (fail) begin
                attempts <= attempts_inc;
                blocking <= 1'b1;
                long_blk <= (attempts_inc > `MAX_ATTEMPTS);
                tmr      <= '0;
            end else if (keypad_release) begin
                blocking <= 1'b0;
            end else if (blocking) begin
                tmr <= tmr + 1'b1;
            end

            if (clear)
                attempts <= '0;  // Correct code forgives earlier failures
        end
    end

    // One bar per failure from digit 0 up, blank otherwise
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            if (blocking && (attempts > i))
                bcd[i] = DIGIT_BAR;
            else
                bcd[i] = DIGIT_BLANK;
        end
    end

endmodule

// ==== door_fsm.sv ====
`timescale 1ns/1ps
`include "lock_settings.svh"

module door_fsm import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       door_open,
    input  logic       inside_button,
    input  logic       config_button,
    input  key_entry_u key_entry,
    input  logic       key_valid,
    input  lock_cfg_t  setup_cfg,
    input  logic       setup_valid,
    code_check_if.ctrl chk,
    output logic       fail,
    output logic       clear,
    input  logic       keypad_release,
    output lock_cfg_t  cfg,
    output logic       keypad_en,
    output logic       setup_on,
    output logic       lock_engaged,
    output logic       beep
);

    localparam int TIME_W = $clog2(255 * `MS_PER_SEC + 1);  // 8-bit seconds field
    localparam int DB_W   = $clog2(`DEBOUNCE_MS + 1);

    // Factory master code 1234
    localparam code_t MASTER_RESET = {{(`CODE_DIGITS - 4){DIGIT_EMPTY}},
                                      4'h1, 4'h2, 4'h3, 4'h4};
    localparam code_t ALL_EMPTY    = {`CODE_DIGITS{DIGIT_EMPTY}};
    localparam code_t ALL_BLANK    = {`CODE_DIGITS{DIGIT_BLANK}};
    localparam code_t ALL_TIMEOUT  = {`CODE_DIGITS{DIGIT_TIMEOUT}};

    door_state_t       state;
    code_t             code_reg;      // Entry under check
    logic [DB_W-1:0]   db_cnt;
    logic [TIME_W-1:0] auto_cnt;
    logic [TIME_W-1:0] beep_cnt;
    logic [TIME_W-1:0] autolock_lim;
    logic [TIME_W-1:0] beep_lim;
    logic              db_done;

    assign db_done      = (db_cnt >= DB_W'(`DEBOUNCE_MS - 1));
    assign autolock_lim = TIME_W'(cfg.autolock_sec * `MS_PER_SEC);
    assign beep_lim     = TIME_W'(cfg.beep_sec * `MS_PER_SEC);

    // Requests to the matcher
    assign chk.start      = (state == ST_USER_CHK) || (state == ST_MASTER_CHK);
    assign chk.master_sel = (state == ST_MASTER_CHK) || (state == ST_MASTER_WAIT);
    assign chk.entry      = code_reg;

    assign fail  = (state == ST_USER_WAIT) && chk.done && !chk.match;
    assign clear = (state == ST_USER_WAIT) && chk.done && chk.match;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= ST_INIT;
            db_cnt           <= '0;
            auto_cnt         <= '0;
            beep_cnt         <= '0;
            cfg.beep_en      <= 1'b1;
            cfg.beep_sec     <= 8'd5;
            cfg.autolock_sec <= 8'd5;
            cfg.master       <= MASTER_RESET;
            cfg.user         <= {`NUM_USER_CODES{ALL_EMPTY}};
        end else begin
            // Each counter runs only in its own states
            db_cnt   <= '0;
            auto_cnt <= '0;
            beep_cnt <= '0;

            case (state)
                ST_INIT: begin
                    if (!door_open)
                        state <= ST_CLOSED;
                end

                ST_CLOSED: begin
                    if (inside_button) begin
                        state <= ST_UNLOCK_DB;
                    end else if (key_valid) begin
                        case (key_entry.command.cmd)
                            DIGIT_BLANK, DIGIT_EMPTY: state <= ST_CLOSED;
                            DIGIT_TIMEOUT:            state <= ST_BEEP_TO;
                            default: begin
                                code_reg <= key_entry.code;
                                state    <= ST_USER_CHK;
                            end
                        endcase
                    end
                end

                ST_UNLOCK_DB: begin
                    if (!inside_button)
                        state <= db_done ? ST_AJAR : ST_CLOSED;  // Unlock on release
                    else
                        db_cnt <= db_done ? db_cnt : db_cnt + 1'b1;
                end

                ST_USER_CHK: state <= ST_USER_WAIT;

                ST_USER_WAIT: begin
                    if (chk.done)
                        state <= chk.match ? ST_AJAR : ST_LOCKOUT;
                end

                ST_LOCKOUT: begin
                    if (keypad_release)
                        state <= ST_CLOSED;
                end

                ST_BEEP_TO: state <= ST_CLOSED;

                ST_AJAR: begin
                    if (door_open)
                        state <= ST_OPEN;
                    else if (inside_button)
                        state <= ST_RELOCK_DB;
                    else if (auto_cnt + 1'b1 >= autolock_lim)
                        state <= ST_CLOSED;            // Auto-lock
                    else
                        auto_cnt <= auto_cnt + 1'b1;
                end

                ST_RELOCK_DB: begin
                    if (db_done)
                        state <= ST_CLOSED;
                    else if (!inside_button)
                        state <= ST_OPEN;
                    else
                        db_cnt <= db_cnt + 1'b1;
                end

                ST_OPEN: begin
                    if (config_button)
                        state <= ST_CFG_DB;
                    else if (!door_open)
                        state <= ST_AJAR;
                    else if (cfg.beep_en && (beep_cnt + 1'b1 >= beep_lim))
                        state <= ST_BEEP_OPEN;
                    else if (cfg.beep_en)
                        beep_cnt <= beep_cnt + 1'b1;
                end

                ST_BEEP_OPEN: begin
                    if (config_button)
                        state <= ST_CFG_DB;
                    else if (!door_open)
                        state <= ST_AJAR;
                end

                ST_CFG_DB: begin
                    if (db_done)
                        state <= ST_MASTER_IDLE;
                    else if (config_button)
                        db_cnt <= db_cnt + 1'b1;
                    else
                        state <= ST_OPEN;
                end

                ST_MASTER_IDLE: begin
                    if (key_valid) begin
                        if (key_entry.code == ALL_BLANK) begin
                            state <= ST_OPEN;                  // "#" leaves
                        end else if (key_entry.code != ALL_TIMEOUT) begin
                            code_reg <= key_entry.code;
                            state    <= ST_MASTER_CHK;
                        end
                    end
                end

                ST_MASTER_CHK: state <= ST_MASTER_WAIT;

                ST_MASTER_WAIT: begin
                    if (chk.done)
                        state <= chk.match ? ST_SETUP : ST_MASTER_IDLE;
                end

                ST_SETUP: begin
                    if (setup_valid) begin
                        cfg   <= setup_cfg;
                        state <= ST_OPEN;
                    end
                end

                default: state <= ST_INIT;
            endcase
        end
    end

    // Outputs follow the state alone
    always_comb begin
        keypad_en    = 1'b0;
        setup_on     = 1'b0;
        lock_engaged = 1'b0;
        beep         = 1'b0;
        case (state)
            ST_CLOSED: begin
                keypad_en    = 1'b1;
                lock_engaged = 1'b1;
            end
            ST_UNLOCK_DB, ST_USER_CHK, ST_USER_WAIT, ST_LOCKOUT: lock_engaged = 1'b1;
            ST_BEEP_TO: begin
                lock_engaged = 1'b1;
                beep         = 1'b1;
            end
            ST_OPEN, ST_MASTER_IDLE: keypad_en = 1'b1;
            ST_BEEP_OPEN: begin
                keypad_en = 1'b1;
                beep      = 1'b1;
            end
            ST_SETUP: begin
                keypad_en = 1'b1;
                setup_on  = 1'b1;
            end
            default: begin
                keypad_en = 1'b0;  // Ajar, debounce and master check states
            end
        endcase
    end

endmodule

// ==== door_lock.sv ====
`timescale 1ns/1ps

module door_lock import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       door_open,
    input  logic       inside_button,
    input  logic       config_button,
    input  key_entry_u key_entry,
    input  logic       key_valid,
    input  lock_cfg_t  setup_cfg,
    input  logic       setup_valid,
    output bcd_t       bcd,
    output logic       keypad_en,
    output logic       setup_on,
    output logic       lock_engaged,
    output logic       beep
);

    logic      fail;
    logic      clear;
    logic      keypad_release;
    lock_cfg_t cfg;               // Live configuration, owned by the FSM

    code_check_if chk ();

    door_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .door_open      (door_open),
        .inside_button  (inside_button),
        .config_button  (config_button),
        .key_entry      (key_entry),
        .key_valid      (key_valid),
        .setup_cfg      (setup_cfg),
        .setup_valid    (setup_valid),
        .chk            (chk.ctrl),
        .fail           (fail),
        .clear          (clear),
        .keypad_release (keypad_release),
        .cfg            (cfg),
        .keypad_en      (keypad_en),
        .setup_on       (setup_on),
        .lock_engaged   (lock_engaged),
        .beep           (beep)
    );

    code_match u_match (
        .clk (clk),
        .rst (rst),
        .cfg (cfg),
        .chk (chk.matcher)
    );

    // Attempt counter drives the display directly
    lockout_ctrl u_lockout (
        .clk            (clk),
        .rst            (rst),
        .fail           (fail),
        .clear          (clear),
        .keypad_release (keypad_release),
        .bcd            (bcd)
    );

endmodule

// ==== door_lock_asserts.sv ====
`timescale 1ns/1ps

module door_lock_asserts import lock_pkg::*; (
    input logic        clk,
    input logic        rst,
    input door_state_t state,
    input logic        chk_start,
    input logic        chk_done,
    input logic        chk_match,
    input logic        lock_engaged,
    input logic        setup_on,
    input logic        beep
);

    logic in_flight;  // Check sent to the matcher, answer still pending

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            in_flight <= 1'b0;
        else if (chk_start)
            in_flight <= 1'b1;
        else if (chk_done)
            in_flight <= 1'b0;
    end

    // Setup is reached only through a matching master check
    assert property (@(posedge clk) disable iff (rst) $rose(setup_on) |-> $past(chk_done && chk_match))
        else $error("setup entered without a matching master code");

    // One code check at a time
    assert property (@(posedge clk) disable iff (rst) chk_start |-> !in_flight)
        else $error("code check started while another was pending");

    // The latch lets go only into the ajar state
    assert property (@(posedge clk) disable iff (rst) $fell(lock_engaged) |-> (state == ST_AJAR))
        else $error("lock released outside the ajar state");

endmodule

bind door_fsm door_lock_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .state        (state),
    .chk_start    (chk.start),
    .chk_done     (chk.done),
    .chk_match    (chk.match),
    .lock_engaged (lock_engaged),
    .setup_on     (setup_on),
    .beep         (beep)
);

// ==== tb_door_lock.sv ====
`timescale 1ns/1ps
`include "lock_settings.svh"

module tb_door_lock import lock_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int MAX_TIME   = 3 * `MS_PER_SEC;  // Random configs use 1 to 3 s
    localparam int WATCHDOG   = `BLOCK_MS + 8 * `RETRY_MS + 8 * MAX_TIME + 20 * `DEBOUNCE_MS;

    logic        clk;
    logic        rst;
    logic        door_open;
    logic        inside_button;
    logic        config_button;
    key_entry_u  key_entry;
    logic        key_valid;
    lock_cfg_t   setup_cfg;
    logic        setup_valid;
    bcd_t        bcd;
    logic        keypad_en;
    logic        setup_on;
    logic        lock_engaged;
    logic        beep;

    logic [31:0] lcg_state = 32'd99725;
    lock_cfg_t   cfg_m;          // Expected stored configuration
    int          attempts_m;     // Expected failure count
    int          errors;
    int          checks;
    int          tests;
    int          errors_before;  // Error count when the current test began

    door_lock DUT (
        .clk           (clk),
        .rst           (rst),
        .door_open     (door_open),
        .inside_button (inside_button),
        .config_button (config_button),
        .key_entry     (key_entry),
        .key_valid     (key_valid),
        .setup_cfg     (setup_cfg),
        .setup_valid   (setup_valid),
        .bcd           (bcd),
        .keypad_en     (keypad_en),
        .setup_on      (setup_on),
        .lock_engaged  (lock_engaged),
        .beep          (beep)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        int r;
        r = int'(lcg_next() >> 16);  // Upper bits, the low ones repeat quickly
        return r % n;
    endfunction

    // 4 to 8 decimal digits, unused digits empty
    function automatic code_t random_code();
        code_t c;
        int    len;
        len = 4 + rand_below(5);
        for (int i = 0; i < `CODE_DIGITS; i++)
            c[i] = (i < len) ? digit_t'(rand_below(10)) : DIGIT_EMPTY;
        return c;
    endfunction

    function automatic logic is_user_code(lock_cfg_t c, code_t k);
        for (int s = 0; s < `NUM_USER_CODES; s++)
            if (c.user[s] == k)
                return 1'b1;
        return 1'b0;
    endfunction

    function automatic lock_cfg_t random_cfg(logic beep_en);
        lock_cfg_t c;
        code_t     k;
        c.beep_en      = beep_en;
        c.beep_sec     = 8'(1 + rand_below(3));
        c.autolock_sec = 8'(1 + rand_below(3));
        c.master       = random_code();
        c.user         = '1;  // All slots empty
        for (int s = 0; s < `NUM_USER_CODES; s++) begin
            do
                k = random_code();
            while (is_user_code(c, k));  // Slots stay distinct
            c.user[s] = k;
        end
        return c;
    endfunction

    function automatic code_t wrong_code();
        code_t k;
        do
            k = random_code();
        while (is_user_code(cfg_m, k) || k == cfg_m.master);
        return k;
    endfunction

    // Lit bars from digit 0 up, capped at the display width
    function automatic bcd_t bars_bcd(int n);
        bcd_t b;
        for (int i = 0; i < 6; i++)
            b[i] = (i < n) ? DIGIT_BAR : DIGIT_BLANK;
        return b;
    endfunction

    function automatic int secs_to_cycles(logic [7:0] s);
        return int'(s) * `MS_PER_SEC;
    endfunction

    function automatic logic out_bit(string name);
        if (name == "lock_engaged")
            return lock_engaged;
        else if (name == "keypad_en")
            return keypad_en;
        else if (name == "setup_on")
            return setup_on;
        else if (name == "beep")
            return beep;
        return 1'bx;
    endfunction

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bcd(bcd_t got, bcd_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH bcd: got %h, expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_cfg(lock_cfg_t got, lock_cfg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH cfg: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp, int tol);
        checks++;
        if (got < exp - tol || got > exp + tol) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Polls at the falling edge, where outputs are settled
    task automatic wait_bit(string name, logic val, int max_cycles, output int cycles);
        cycles = 0;
        while (out_bit(name) !== val && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (out_bit(name) !== val) begin
            errors++;
            $display("Gave up after %0d cycles waiting for %s to become %0b",
                     max_cycles, name, val);
        end
    endtask

    task automatic wait_bcd(logic blank, int max_cycles, output int cycles);
        cycles = 0;
        while (((bcd === bars_bcd(0)) != blank) && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if ((bcd === bars_bcd(0)) != blank) begin
            errors++;
            $display("Gave up after %0d cycles waiting for the display to turn %s",
                     max_cycles, blank ? "blank" : "lit");
        end
    endtask

    task automatic send_key(code_t c);
        key_entry.code = c;
        key_valid      = 1'b1;
        @(negedge clk);
        key_valid      = 1'b0;
    endtask

    task automatic unlock_from_inside();
        int n;
        inside_button = 1'b1;
        repeat (`DEBOUNCE_MS) @(negedge clk);
        inside_button = 1'b0;
        check_bit("lock_engaged", lock_engaged, 1'b1);  // Latch waits for the release
        wait_bit("lock_engaged", 1'b0, 3, n);
    endtask

    // Door must be open; leaves it open with the new configuration loaded
    task automatic enter_setup(lock_cfg_t new_cfg, logic try_wrong);
        int n;
        config_button = 1'b1;
        repeat (`DEBOUNCE_MS) @(negedge clk);
        config_button = 1'b0;
        wait_bit("keypad_en", 1'b1, 3, n);
        if (try_wrong) begin
            send_key(wrong_code());
            repeat (6) @(negedge clk);
            check_bit("setup_on", setup_on, 1'b0);
            check_bit("keypad_en", keypad_en, 1'b1);
        end
        send_key(cfg_m.master);
        wait_bit("setup_on", 1'b1, 5, n);
        setup_cfg   = new_cfg;
        setup_valid = 1'b1;
        @(negedge clk);
        setup_valid = 1'b0;
        wait_bit("setup_on", 1'b0, 3, n);
        cfg_m = new_cfg;
        check_cfg(DUT.u_fsm.cfg, cfg_m);
    endtask

    task automatic open_with_user(int slot);
        int n;
        send_key(cfg_m.user[slot]);
        wait_bit("lock_engaged", 1'b0, `NUM_USER_CODES + 3, n);
        attempts_m = 0;
    endtask

    task automatic wrong_attempt();
        int n;
        int exp_len;
        attempts_m++;
        exp_len = (attempts_m > `MAX_ATTEMPTS) ? `BLOCK_MS : `RETRY_MS;
        send_key(wrong_code());
        wait_bcd(1'b0, `NUM_USER_CODES + 4, n);
        check_bcd(bcd, bars_bcd(attempts_m));
        check_bit("keypad_en", keypad_en, 1'b0);
        check_bit("lock_engaged", lock_engaged, 1'b1);
        wait_bcd(1'b1, exp_len + 4, n);
        check_count("lockout cycles", n, exp_len, 2);
        check_bit("keypad_en", keypad_en, 1'b1);
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        int         n;
        int         lim;
        key_entry_u k;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        errors_before = 0;
        attempts_m    = 0;
        door_open     = 1'b0;
        inside_button = 1'b0;
        config_button = 1'b0;
        key_entry     = '1;
        key_valid     = 1'b0;
        setup_cfg     = '0;
        setup_valid   = 1'b0;
        rst           = 1'b1;
        cfg_m         = '1;
        cfg_m.master  = {{(`CODE_DIGITS - 4){DIGIT_EMPTY}}, 4'h1, 4'h2, 4'h3, 4'h4};

        repeat (10) @(negedge clk);
        check_bit("lock_engaged", lock_engaged, 1'b0);
        check_bit("keypad_en", keypad_en, 1'b0);
        rst = 1'b0;
        wait_bit("lock_engaged", 1'b1, 2, n);
        check_bit("keypad_en", keypad_en, 1'b1);
        check_bit("beep", beep, 1'b0);
        check_bit("setup_on", setup_on, 1'b0);
        check_bcd(bcd, bars_bcd(0));
        end_test("reset");

        unlock_from_inside();
        door_open = 1'b1;
        @(negedge clk);
        enter_setup(random_cfg(1'b1), 1'b1);
        end_test("setup");

        door_open = 1'b0;
        lim = secs_to_cycles(cfg_m.autolock_sec);
        wait_bit("lock_engaged", 1'b1, lim + 4, n);
        open_with_user(rand_below(`NUM_USER_CODES));
        wait_bit("lock_engaged", 1'b1, lim + 4, n);
        check_count("auto-lock cycles", n, lim, 2);
        end_test("user code");

        repeat (6) wrong_attempt();
        open_with_user(rand_below(`NUM_USER_CODES));
        wait_bit("lock_engaged", 1'b1, lim + 4, n);
        wrong_attempt();                          // Count starts over at one bar
        end_test("wrong codes");

        // Timeout key, read by its low digit only
        k.code        = random_code();
        k.command.cmd = DIGIT_TIMEOUT;
        send_key(k.code);
        n = 0;
        repeat (6) begin
            if (beep)
                n++;
            @(negedge clk);
        end
        check_count("timeout beep cycles", n, 1, 0);

        unlock_from_inside();
        door_open = 1'b1;
        lim = secs_to_cycles(cfg_m.beep_sec);
        wait_bit("beep", 1'b1, lim + 4, n);
        check_count("open beep delay", n, lim, 2);
        n = 0;
        repeat (50) begin
            if (beep)
                n++;
            @(negedge clk);
        end
        check_count("open beep cycles", n, 50, 0);
        door_open = 1'b0;
        @(negedge clk);
        check_bit("beep", beep, 1'b0);
        door_open = 1'b1;
        @(negedge clk);
        enter_setup(random_cfg(1'b0), 1'b0);
        lim = secs_to_cycles(cfg_m.beep_sec);
        n = 0;
        repeat (lim + 200) begin
            if (beep)
                n++;
            @(negedge clk);
        end
        check_count("beep cycles with beep_en off", n, 0, 0);
        door_open = 1'b0;
        wait_bit("lock_engaged", 1'b1, secs_to_cycles(cfg_m.autolock_sec) + 4, n);
        end_test("beeps");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
lock_pkg.sv
code_check_if.sv
code_match.sv
lockout_ctrl.sv
door_fsm.sv
door_lock.sv
door_lock_asserts.sv
tb_door_lock.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_door_lock -o sim_door_lock

status=0
./obj_dir/sim_door_lock > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
